// ==== vlog.f ====
verilog/csr_addr_pkg.sv
verilog/csr_types_pkg.sv
verilog/csr_write_port.sv
verilog/csr_priv_regs.sv
verilog/csr_timer.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
test/tb_clock.sv
test/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_block

sources:
  - verilog/csr_addr_pkg.sv
  - verilog/csr_types_pkg.sv
  - verilog/csr_write_port.sv
  - verilog/csr_priv_regs.sv
  - verilog/csr_timer.sv
  - verilog/csr_read_mux.sv
  - verilog/csr_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/csr_tb.sv

// ==== test/csr_tb.sv ====
`default_nettype none

module csr_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  localparam int n_writes  = 24;
  localparam int max_iv    = 8;
  localparam int timer_len = 4 * max_iv + 2;
  // reset, masked writes, short directed steps, three timer waits
  localparam int cycle_limit = 10 + 2 * n_writes + 80 + 3 * (timer_len + 8);

  logic        clk;
  logic        rst_n;
  logic        stall_i;
  logic        csr_we_i;
  logic        valid_i;
  logic        commit_i;
  csr_addr_t   csr_w_addr_i;
  logic [31:0] csr_w_mask_i;
  logic [31:0] csr_w_data_i;
  csr_addr_t   csr_r_addr_i;
  rdcnt_t      rdcnt_i;
  excp_t       excp_i;
  logic        ertn_i;
  logic [31:0] csr_r_data_o;
  csr_state_t  csr_o;

  csr_state_t  m_st;
  logic [31:0] m_save [4];
  logic [31:0] m_tid;
  logic [31:0] lfsr_q;
  int          n_checks;
  int          n_errors;
  int          cycles;
  logic        rd_pend;
  logic [31:0] rd_exp;
  string       rd_name;
  logic        due;
  logic [31:0] due_exp;
  string       due_name;

  tb_clock clock0 (.clk_o(clk), .rst_n_o(rst_n));

  csr_top dut0 (
    .clk(clk), .rst_n(rst_n), .stall_i(stall_i),
    .csr_we_i(csr_we_i), .valid_i(valid_i), .commit_i(commit_i),
    .csr_w_addr_i(csr_w_addr_i), .csr_w_mask_i(csr_w_mask_i), .csr_w_data_i(csr_w_data_i),
    .csr_r_addr_i(csr_r_addr_i), .rdcnt_i(rdcnt_i), .excp_i(excp_i), .ertn_i(ertn_i),
    .csr_r_data_o(csr_r_data_o), .csr_o(csr_o)
  );

  // fibonacci lfsr on taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      v      = {v[30:0], lfsr_q[31]};
      lfsr_q = {lfsr_q[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] writable(input csr_addr_t addr);
    case (addr)
      csr_crmd:   return 32'h0000_01ff;
      csr_prmd:   return 32'h0000_0007;
      csr_estat:  return 32'h0000_0003;
      csr_eentry: return 32'hffff_ffc0;
      csr_era, csr_tid, csr_tcfg: return '1;
      csr_save0, csr_save1, csr_save2, csr_save3: return '1;
      default:    return '0;
    endcase
  endfunction

  // expected register after a masked write
  function automatic logic [31:0] merge_ref(input csr_addr_t addr, input logic [31:0] old,
                                            input logic [31:0] mask, input logic [31:0] data);
    logic [31:0] keep;
    logic [31:0] next;
    keep = writable(addr);
    next = old;
    for (int i = 0; i < 32; i++) begin
      // new bit where both the mask and the field allow it
      if (mask[i] && keep[i]) begin
        next[i] = data[i];
      end
    end
    return next;
  endfunction

  function automatic logic [31:0] model_get(input csr_addr_t addr);
    case (addr)
      csr_crmd:   return m_st.crmd;
      csr_prmd:   return m_st.prmd;
      csr_estat:  return m_st.estat;
      csr_era:    return m_st.era;
      csr_eentry: return m_st.eentry;
      csr_save0:  return m_save[0];
      csr_save1:  return m_save[1];
      csr_save2:  return m_save[2];
      csr_save3:  return m_save[3];
      csr_tid:    return m_tid;
      csr_tcfg:   return m_st.tcfg;
      default:    return '0;
    endcase
  endfunction

  task automatic model_set(input csr_addr_t addr, input logic [31:0] v);
    case (addr)
      csr_crmd:   m_st.crmd = v;
      csr_prmd:   m_st.prmd = v;
      csr_estat:  m_st.estat = v;
      csr_era:    m_st.era = v;
      csr_eentry: m_st.eentry = v;
      csr_save0:  m_save[0] = v;
      csr_save1:  m_save[1] = v;
      csr_save2:  m_save[2] = v;
      csr_save3:  m_save[3] = v;
      csr_tid:    m_tid = v;
      csr_tcfg:   m_st.tcfg = v;
      default: ;
    endcase
  endtask

  function automatic csr_addr_t pick_target(input int idx);
    case (idx)
      0:       return csr_save0;
      1:       return csr_save1;
      2:       return csr_save2;
      3:       return csr_save3;
      4:       return csr_crmd;
      5:       return csr_prmd;
      default: return csr_eentry;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERR %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input csr_state_t exp, input csr_state_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one write request cycle with caller given qualifiers
  task automatic drive_write(input csr_addr_t addr, input logic [31:0] mask,
                             input logic [31:0] data, input logic stall,
                             input logic valid, input logic commit);
    csr_w_addr_i = addr;
    csr_w_mask_i = mask;
    csr_w_data_i = data;
    stall_i      = stall;
    valid_i      = valid;
    commit_i     = commit;
    csr_we_i     = 1'b1;
    @(posedge clk);
    #1;
    csr_we_i = 1'b0;
    valid_i  = 1'b0;
    commit_i = 1'b0;
    stall_i  = 1'b0;
  endtask

  task automatic write_csr(input csr_addr_t addr, input logic [31:0] mask,
                           input logic [31:0] data);
    logic [31:0] next;
    next = merge_ref(addr, model_get(addr), mask, data);
    drive_write(addr, mask, data, 1'b0, 1'b1, 1'b1);
    model_set(addr, next);
  endtask

  task automatic issue_read(input string name, input csr_addr_t addr, input rdcnt_t cnt,
                            input logic [31:0] exp);
    csr_r_addr_i = addr;
    rdcnt_i      = cnt;
    rd_pend      = 1'b1;
    rd_exp       = exp;
    rd_name      = name;
    @(posedge clk);
    #1;
    rd_pend = 1'b0;
    rdcnt_i = cnt_none;
  endtask

  task automatic read_now(input rdcnt_t cnt, output logic [31:0] v);
    rdcnt_i = cnt;
    @(posedge clk);
    #1;
    v       = csr_r_data_o;
    rdcnt_i = cnt_none;
  endtask

  // counts edges since the request that started the timer
  task automatic wait_irq(input string name, output int n);
    n = 1;
    while (!csr_o.estat[estat_ti] && n < timer_len + 4) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!csr_o.estat[estat_ti]) begin
      n_errors++;
      $display("%s: timer interrupt did not arrive within %0d cycles", name, n);
    end
  endtask

  // read data lands one edge after the request
  always begin
    @(posedge clk);
    due      = rd_pend;
    due_exp  = rd_exp;
    due_name = rd_name;
    @(negedge clk);
    if (due) begin
      check_word(due_name, due_exp, csr_r_data_o);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped: cycle limit of %0d reached", cycle_limit);
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    csr_addr_t   addr;
    logic [31:0] mask;
    logic [31:0] data;
    logic [31:0] v0;
    logic [31:0] v1;
    int          k;
    int          n;
    int          iv;
    csr_state_t  exp_st;
    excp_t       ev;

    stall_i      = 1'b0;
    csr_we_i     = 1'b0;
    valid_i      = 1'b0;
    commit_i     = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    csr_r_addr_i = '0;
    rdcnt_i      = cnt_none;
    excp_i       = '0;
    ertn_i       = 1'b0;
    lfsr_q       = 32'd92143;
    n_checks     = 0;
    n_errors     = 0;
    cycles       = 0;
    rd_pend      = 1'b0;
    rd_exp       = '0;
    rd_name      = "";
    m_st         = '0;
    m_st.crmd    = crmd_reset;
    m_tid        = '0;
    for (int i = 0; i < 4; i++) begin
      m_save[i] = '0;
    end

    @(posedge rst_n);
    repeat (2) @(posedge clk);
    #1;

    for (int i = 0; i < n_writes; i++) begin
      addr = pick_target(int'(rand_bits(3) % 7));
      mask = rand_bits(32);
      data = rand_bits(32);
      write_csr(addr, mask, data);
      issue_read("masked write", addr, cnt_none, model_get(addr));
    end

    // writes that must not land
    data = rand_bits(32);
    drive_write(csr_save0, '1, data, 1'b1, 1'b1, 1'b1);
    drive_write(csr_save0, '1, data, 1'b0, 1'b1, 1'b0);
    drive_write(csr_save0, '1, data, 1'b0, 1'b0, 1'b1);
    issue_read("blocked write", csr_save0, cnt_none, m_save[0]);
    stall_i      = 1'b1;
    csr_r_addr_i = csr_save1;
    repeat (3) begin
      @(posedge clk);
      #1;
      check_word("stall hold", m_save[0], csr_r_data_o);
    end
    stall_i = 1'b0;

    write_csr(csr_crmd, 32'h7, 32'h7);
    ev.valid    = 1'b1;
    ev.ecode    = 6'(rand_bits(6));
    ev.esubcode = 9'(rand_bits(9));
    ev.pc       = rand_bits(32);
    exp_st = m_st;
    exp_st.prmd[prmd_pplv_hi:prmd_pplv_lo] = m_st.crmd[crmd_plv_hi:crmd_plv_lo];
    exp_st.prmd[prmd_pie]                  = m_st.crmd[crmd_ie];
    exp_st.crmd[crmd_plv_hi:crmd_plv_lo]   = 2'b00;
    exp_st.crmd[crmd_ie]                   = 1'b0;
    exp_st.era                             = ev.pc;
    exp_st.estat[estat_ecode_hi:estat_ecode_lo]       = ev.ecode;
    exp_st.estat[estat_esubcode_hi:estat_esubcode_lo] = ev.esubcode;
    excp_i = ev;
    @(posedge clk);
    #1;
    excp_i = '0;
    m_st   = exp_st;
    check_state("exception entry", m_st, csr_o);
    issue_read("exception era", csr_era, cnt_none, m_st.era);
    issue_read("exception estat", csr_estat, cnt_none, m_st.estat);
    ertn_i = 1'b1;
    @(posedge clk);
    #1;
    ertn_i = 1'b0;
    m_st.crmd[crmd_plv_hi:crmd_plv_lo] = m_st.prmd[prmd_pplv_hi:prmd_pplv_lo];
    m_st.crmd[crmd_ie]                 = m_st.prmd[prmd_pie];
    check_state("ertn return", m_st, csr_o);

    // one-shot timer
    iv = 1 + int'(rand_bits(3));
    write_csr(csr_tcfg, '1, {30'(iv), 2'b01});
    wait_irq("one-shot timer", n);
    check_word("one-shot delay", 4 * iv + 2, n);
    check_word("one-shot tval", '1, csr_o.tval);
    issue_read("one-shot tval read", csr_tval, cnt_none, '1);
    issue_read("tcfg readback", csr_tcfg, cnt_none, m_st.tcfg);
    m_st.estat[estat_ti] = 1'b1;
    issue_read("timer irq in estat", csr_estat, cnt_none, m_st.estat);
    write_csr(csr_ticlr, '1, 32'h1);
    m_st.estat[estat_ti] = 1'b0;
    issue_read("ticlr clear", csr_estat, cnt_none, m_st.estat);

    // periodic timer
    iv = 1 + int'(rand_bits(3));
    write_csr(csr_tcfg, '1, {30'(iv), 2'b11});
    wait_irq("periodic timer", n);
    check_word("periodic delay", 4 * iv + 2, n);
    check_word("periodic reload", 4 * iv, csr_o.tval);
    write_csr(csr_ticlr, '1, 32'h1);
    check_word("periodic clear", 32'h0, {31'h0, csr_o.estat[estat_ti]});
    wait_irq("periodic second period", n);
    check_word("periodic second reload", 4 * iv, csr_o.tval);
    write_csr(csr_tcfg, '1, 32'h0);
    write_csr(csr_ticlr, '1, 32'h1);

    k = 2 + int'(rand_bits(3) % 6);
    read_now(cnt_vlow, v0);
    repeat (k - 1) begin
      @(posedge clk);
      #1;
    end
    read_now(cnt_vlow, v1);
    check_word("rdcnt vlow distance", v0 + k, v1);
    write_csr(csr_tid, '1, rand_bits(32));
    issue_read("rdcnt id", csr_crmd, cnt_id, m_tid);

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held over the first 5 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/csr_top.sv ====
`default_nettype none

module csr_top (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      stall_i,
  input  wire logic                      csr_we_i,
  input  wire logic                      valid_i,
  input  wire logic                      commit_i,
  input  wire csr_types_pkg::csr_addr_t  csr_w_addr_i,
  input  wire logic [31:0]               csr_w_mask_i,
  input  wire logic [31:0]               csr_w_data_i,
  input  wire csr_types_pkg::csr_addr_t  csr_r_addr_i,
  input  wire csr_types_pkg::rdcnt_t     rdcnt_i,
  input  wire csr_types_pkg::excp_t      excp_i,
  input  wire logic                      ertn_i,
  output logic [31:0]                    csr_r_data_o,
  output csr_types_pkg::csr_state_t      csr_o
);

  import csr_types_pkg::*;

  csr_wr_t          wr;
  csr_word_u        old_data;
  csr_state_t       priv_state;
  logic [3:0][31:0] save;
  logic [31:0]      tcfg;
  logic [31:0]      tval;
  logic [31:0]      tid;
  logic             timer_irq;
  logic [63:0]      counter;

  csr_write_port write_port0 (
    .clk(clk), .rst_n(rst_n), .stall_i(stall_i),
    .we_i(csr_we_i), .valid_i(valid_i), .commit_i(commit_i),
    .w_addr_i(csr_w_addr_i), .w_mask_i(csr_w_mask_i), .w_data_i(csr_w_data_i),
    .old_data_i(old_data), .wr_o(wr)
  );

  csr_priv_regs priv_regs0 (
    .clk(clk), .rst_n(rst_n), .wr_i(wr),
    .excp_i(excp_i), .ertn_i(ertn_i), .timer_irq_i(timer_irq),
    .state_o(priv_state), .save_o(save)
  );

  csr_timer timer0 (
    .clk(clk), .rst_n(rst_n), .wr_i(wr),
    .tcfg_o(tcfg), .tval_o(tval), .tid_o(tid),
    .timer_irq_o(timer_irq), .counter_o(counter)
  );

  // reads see the assembled state
  csr_read_mux read_mux0 (
    .clk(clk), .rst_n(rst_n), .stall_i(stall_i),
    .r_addr_i(csr_r_addr_i), .rdcnt_i(rdcnt_i), .w_addr_i(csr_w_addr_i),
    .state_i(csr_o), .save_i(save), .tid_i(tid), .counter_i(counter),
    .r_data_o(csr_r_data_o), .old_data_o(old_data)
  );

  assign csr_o = '{crmd: priv_state.crmd, prmd: priv_state.prmd, estat: priv_state.estat,
                   era: priv_state.era, eentry: priv_state.eentry, tcfg: tcfg, tval: tval};

endmodule

`default_nettype wire

// ==== verilog/csr_read_mux.sv ====
`default_nettype none

module csr_read_mux (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      stall_i,
  input  wire csr_types_pkg::csr_addr_t  r_addr_i,
  input  wire csr_types_pkg::rdcnt_t     rdcnt_i,
  input  wire csr_types_pkg::csr_addr_t  w_addr_i,
  input  wire csr_types_pkg::csr_state_t state_i,
  input  wire logic [3:0][31:0]          save_i,
  input  wire logic [31:0]               tid_i,
  input  wire logic [63:0]               counter_i,
  output logic [31:0]                    r_data_o,
  output csr_types_pkg::csr_word_u       old_data_o
);

  import csr_addr_pkg::*;
  import csr_types_pkg::*;

  logic [31:0] rd_sel;

  function automatic logic [31:0] lookup(input csr_addr_t addr, input csr_state_t st,
                                         input logic [3:0][31:0] sv, input logic [31:0] tid);
    case (addr)
      csr_crmd:   return st.crmd;
      csr_prmd:   return st.prmd;
      csr_estat:  return st.estat;
      csr_era:    return st.era;
      csr_eentry: return st.eentry;
      csr_save0:  return sv[0];
      csr_save1:  return sv[1];
      csr_save2:  return sv[2];
      csr_save3:  return sv[3];
      csr_tid:    return tid;
      csr_tcfg:   return st.tcfg;
      csr_tval:   return st.tval;
      // ticlr and unmapped addresses
      default:    return '0;
    endcase
  endfunction

  // rdcnt wins over the csr address
  always_comb begin
    case (rdcnt_i)
      cnt_id:    rd_sel = tid_i;
      cnt_vlow:  rd_sel = counter_i[31:0];
      cnt_vhigh: rd_sel = counter_i[63:32];
      default:   rd_sel = lookup(r_addr_i, state_i, save_i, tid_i);
    endcase
  end

  // hold while M2 is stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_data_o <= '0;
    end else if (!stall_i) begin
      r_data_o <= rd_sel;
    end
  end

  // pre-write value for the mask merge
  assign old_data_o = lookup(w_addr_i, state_i, save_i, tid_i);

endmodule

`default_nettype wire

// ==== verilog/csr_timer.sv ====
`default_nettype none

module csr_timer (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire csr_types_pkg::csr_wr_t wr_i,
  output logic [31:0]                 tcfg_o,
  output logic [31:0]                 tval_o,
  output logic [31:0]                 tid_o,
  output logic                        timer_irq_o,
  output logic [63:0]                 counter_o
);

  import csr_addr_pkg::*;

  logic armed_q;
  logic wr_tcfg;
  logic wr_ticlr;
  logic wr_tid;

  assign wr_tcfg  = wr_i.en && (wr_i.addr == csr_tcfg);
  assign wr_ticlr = wr_i.en && (wr_i.addr == csr_ticlr);
  assign wr_tid   = wr_i.en && (wr_i.addr == csr_tid);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_o <= '0;
      tid_o  <= '0;
    end else begin
      if (wr_tcfg) begin
        tcfg_o[tcfg_en]                         <= wr_i.data.tcfg.en;
        tcfg_o[tcfg_periodic]                   <= wr_i.data.tcfg.periodic;
        tcfg_o[tcfg_initval_hi:tcfg_initval_lo] <= wr_i.data.tcfg.initval;
      end
      if (wr_tid) begin
        tid_o <= wr_i.data.raw;
      end
    end
  end

  // countdown, initval counts in units of 4 cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed_q     <= 1'b0;
      tval_o      <= '0;
      timer_irq_o <= 1'b0;
    end else begin
      if (wr_tcfg) begin
        armed_q <= wr_i.data.tcfg.en;
        tval_o  <= {wr_i.data.tcfg.initval, 2'b00};
      end else if (armed_q) begin
        if (tval_o != '0) begin
          tval_o <= tval_o - 32'd1;
        end else begin
          // expired: one-shot parks at all ones
          timer_irq_o <= 1'b1;
          armed_q     <= tcfg_o[tcfg_periodic];
          tval_o      <= tcfg_o[tcfg_periodic] ?
                         {tcfg_o[tcfg_initval_hi:tcfg_initval_lo], 2'b00} : '1;
        end
      end
      if (wr_ticlr && wr_i.data.raw[ticlr_clr]) begin
        timer_irq_o <= 1'b0;
      end
    end
  end

  // stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counter_o <= '0;
    end else begin
      counter_o <= counter_o + 64'd1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/csr_priv_regs.sv ====
`default_nettype none

module csr_priv_regs (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire csr_types_pkg::csr_wr_t  wr_i,
  input  wire csr_types_pkg::excp_t    excp_i,
  input  wire logic                    ertn_i,
  input  wire logic                    timer_irq_i,
  output csr_types_pkg::csr_state_t    state_o,
  output logic [3:0][31:0]             save_o
);

  import csr_addr_pkg::*;

  logic [31:0] crmd_q;
  logic [31:0] prmd_q;
  logic [1:0]  swi_q;
  logic [5:0]  ecode_q;
  logic [8:0]  esubcode_q;
  logic [31:0] era_q;
  logic [31:0] eentry_q;
  logic [estat_is_hi-estat_is_lo:0] is_bits;
  logic [31:0] estat;
  logic        wr_crmd;
  logic        wr_prmd;
  logic        wr_estat;
  logic        wr_era;
  logic        wr_eentry;

  assign wr_crmd   = wr_i.en && (wr_i.addr == csr_crmd);
  assign wr_prmd   = wr_i.en && (wr_i.addr == csr_prmd);
  assign wr_estat  = wr_i.en && (wr_i.addr == csr_estat);
  assign wr_era    = wr_i.en && (wr_i.addr == csr_era);
  assign wr_eentry = wr_i.en && (wr_i.addr == csr_eentry);

  // mode bits, a software write lands last
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= crmd_reset;
      prmd_q <= '0;
    end else begin
      if (excp_i.valid) begin
        prmd_q[prmd_pplv_hi:prmd_pplv_lo] <= crmd_q[crmd_plv_hi:crmd_plv_lo];
        prmd_q[prmd_pie]                  <= crmd_q[crmd_ie];
        crmd_q[crmd_plv_hi:crmd_plv_lo]   <= 2'b00;
        crmd_q[crmd_ie]                   <= 1'b0;
      end else if (ertn_i) begin
        crmd_q[crmd_plv_hi:crmd_plv_lo] <= prmd_q[prmd_pplv_hi:prmd_pplv_lo];
        crmd_q[crmd_ie]                 <= prmd_q[prmd_pie];
      end
      if (wr_crmd) begin
        crmd_q[crmd_plv_hi:crmd_plv_lo]   <= wr_i.data.crmd.plv;
        crmd_q[crmd_ie]                   <= wr_i.data.crmd.ie;
        crmd_q[crmd_da]                   <= wr_i.data.crmd.da;
        crmd_q[crmd_pg]                   <= wr_i.data.crmd.pg;
        crmd_q[crmd_datf_hi:crmd_datf_lo] <= wr_i.data.crmd.datf;
        crmd_q[crmd_datm_hi:crmd_datm_lo] <= wr_i.data.crmd.datm;
      end
      if (wr_prmd) begin
        prmd_q[prmd_pplv_hi:prmd_pplv_lo] <= wr_i.data.raw[prmd_pplv_hi:prmd_pplv_lo];
        prmd_q[prmd_pie]                  <= wr_i.data.raw[prmd_pie];
      end
    end
  end

  // exception cause, return address and entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      swi_q      <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
      era_q      <= '0;
      eentry_q   <= '0;
    end else begin
      if (excp_i.valid) begin
        ecode_q    <= excp_i.ecode;
        esubcode_q <= excp_i.esubcode;
        era_q      <= excp_i.pc;
      end
      if (wr_estat) begin
        swi_q <= wr_i.data.raw[estat_is_lo +: 2];
      end
      if (wr_era) begin
        era_q <= wr_i.data.raw;
      end
      if (wr_eentry) begin
        eentry_q[eentry_va_hi:eentry_va_lo] <= wr_i.data.raw[eentry_va_hi:eentry_va_lo];
      end
    end
  end

  // scratch registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      save_o <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr_i.en && (wr_i.addr == csr_save0 + csr_addr_w'(i))) begin
          save_o[i] <= wr_i.data.raw;
        end
      end
    end
  end

  always_comb begin
    is_bits                         = '0;
    is_bits[1:0]                    = swi_q;
    is_bits[estat_ti - estat_is_lo] = timer_irq_i;
    estat                                   = '0;
    estat[estat_is_hi:estat_is_lo]          = is_bits;
    estat[estat_ecode_hi:estat_ecode_lo]    = ecode_q;
    estat[estat_esubcode_hi:estat_esubcode_lo] = esubcode_q;
  end

  // timer words come from csr_timer
  assign state_o = '{crmd: crmd_q, prmd: prmd_q, estat: estat, era: era_q,
                     eentry: eentry_q, tcfg: '0, tval: '0};

endmodule

`default_nettype wire

// ==== verilog/csr_write_port.sv ====
`default_nettype none

module csr_write_port (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     stall_i,
  input  wire logic                     we_i,
  input  wire logic                     valid_i,
  input  wire logic                     commit_i,
  input  wire csr_types_pkg::csr_addr_t w_addr_i,
  input  wire logic [31:0]              w_mask_i,
  input  wire logic [31:0]              w_data_i,
  input  wire csr_types_pkg::csr_word_u old_data_i,
  output csr_types_pkg::csr_wr_t        wr_o
);

  logic        live_q;
  logic        take;
  logic [31:0] merged;

  // writes open one cycle after reset release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  // only a committed, unstalled M2 write gets through
  assign take = live_q && we_i && valid_i && commit_i && !stall_i;

  // mask bit set takes new data, clear keeps old
  assign merged = (old_data_i.raw & ~w_mask_i) | (w_data_i & w_mask_i);

  assign wr_o = '{en: take, addr: w_addr_i, data: merged};

endmodule

`default_nettype wire

// ==== verilog/csr_types_pkg.sv ====
`default_nettype none

package csr_types_pkg;

  typedef logic [csr_addr_pkg::csr_addr_w-1:0] csr_addr_t;

  typedef struct packed {
    logic [22:0] reserved;
    logic [1:0]  datm;
    logic [1:0]  datf;
    logic        pg;
    logic        da;
    logic        ie;
    logic [1:0]  plv;
  } crmd_view_t;

  typedef struct packed {
    logic [29:0] initval;
    logic        periodic;
    logic        en;
  } tcfg_view_t;

  // one data word, decoded by the target address
  typedef union packed {
    logic [31:0] raw;
    crmd_view_t  crmd;
    tcfg_view_t  tcfg;
  } csr_word_u;

  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_word_u data;
  } csr_wr_t;

  typedef struct packed {
    logic        valid;
    logic [5:0]  ecode;
    logic [8:0]  esubcode;
    logic [31:0] pc;
  } excp_t;

  typedef struct packed {
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] tcfg;
    logic [31:0] tval;
  } csr_state_t;

  typedef enum logic [1:0] {
    cnt_none  = csr_addr_pkg::rdcnt_none,
    cnt_id    = csr_addr_pkg::rdcnt_id,
    cnt_vlow  = csr_addr_pkg::rdcnt_vlow,
    cnt_vhigh = csr_addr_pkg::rdcnt_vhigh
  } rdcnt_t;

endpackage

`default_nettype wire

// ==== verilog/csr_addr_pkg.sv ====
`default_nettype none

package csr_addr_pkg;

  localparam int unsigned csr_addr_w = 14;

  // register map
  localparam logic [csr_addr_w-1:0] csr_crmd   = 14'h000;
  localparam logic [csr_addr_w-1:0] csr_prmd   = 14'h001;
  localparam logic [csr_addr_w-1:0] csr_estat  = 14'h005;
  localparam logic [csr_addr_w-1:0] csr_era    = 14'h006;
  localparam logic [csr_addr_w-1:0] csr_eentry = 14'h00c;
  localparam logic [csr_addr_w-1:0] csr_save0  = 14'h030;
  localparam logic [csr_addr_w-1:0] csr_save1  = 14'h031;
  localparam logic [csr_addr_w-1:0] csr_save2  = 14'h032;
  localparam logic [csr_addr_w-1:0] csr_save3  = 14'h033;
  localparam logic [csr_addr_w-1:0] csr_tid    = 14'h040;
  localparam logic [csr_addr_w-1:0] csr_tcfg   = 14'h041;
  localparam logic [csr_addr_w-1:0] csr_tval   = 14'h042;
  localparam logic [csr_addr_w-1:0] csr_ticlr  = 14'h044;

  // rdcnt instruction select
  localparam logic [1:0] rdcnt_none  = 2'd0;
  localparam logic [1:0] rdcnt_id    = 2'd1;
  localparam logic [1:0] rdcnt_vlow  = 2'd2;
  localparam logic [1:0] rdcnt_vhigh = 2'd3;

  // crmd
  localparam int unsigned crmd_plv_lo  = 0;
  localparam int unsigned crmd_plv_hi  = 1;
  localparam int unsigned crmd_ie      = 2;
  localparam int unsigned crmd_da      = 3;
  localparam int unsigned crmd_pg      = 4;
  localparam int unsigned crmd_datf_lo = 5;
  localparam int unsigned crmd_datf_hi = 6;
  localparam int unsigned crmd_datm_lo = 7;
  localparam int unsigned crmd_datm_hi = 8;

  // prmd
  localparam int unsigned prmd_pplv_lo = 0;
  localparam int unsigned prmd_pplv_hi = 1;
  localparam int unsigned prmd_pie     = 2;

  // estat, timer interrupt sits in is[11]
  localparam int unsigned estat_is_lo       = 0;
  localparam int unsigned estat_is_hi       = 12;
  localparam int unsigned estat_ti          = 11;
  localparam int unsigned estat_ecode_lo    = 16;
  localparam int unsigned estat_ecode_hi    = 21;
  localparam int unsigned estat_esubcode_lo = 22;
  localparam int unsigned estat_esubcode_hi = 30;

  // timer config and clear
  localparam int unsigned tcfg_en         = 0;
  localparam int unsigned tcfg_periodic   = 1;
  localparam int unsigned tcfg_initval_lo = 2;
  localparam int unsigned tcfg_initval_hi = 31;
  localparam int unsigned ticlr_clr       = 0;

  localparam int unsigned eentry_va_lo = 6;
  localparam int unsigned eentry_va_hi = 31;

  // direct address mode out of reset
  localparam logic [31:0] crmd_reset = 32'h1 << crmd_da;

endpackage

`default_nettype wire
